/* sim.f */
riscv_pkg.sv
trace_pkg.sv
commit_classifier.sv
pc_queue.sv
pc_rr_arbiter.sv
commit_tracer.sv
commit_tracer_chk.sv
tb_commit_tracer.sv

/* run_sim.sh */
#!/bin/sh
# build and run the commit tracer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
  --top-module tb_commit_tracer -f sim.f -o tb_commit_tracer

status=0
./obj_dir/tb_commit_tracer > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "sim failed" sim.log; then
  echo "FAIL: see sim.log"
  exit 1
fi
echo "PASS"

/* tb_commit_tracer.sv */
`timescale 1ns/1ps

module tb_commit_tracer;

  import riscv_pkg::*;
  import trace_pkg::*;

  localparam int N_DIRECTED = 9;
  localparam int N_RANDOM   = 24;
  localparam int N_BURST    = 44;
  localparam int N_ROWS     = N_DIRECTED + N_RANDOM + N_BURST;
  // reset, table, draining both full queues, margin
  localparam int TIMEOUT_CYCLES = 8 + N_ROWS + PC_QUEUE_DEPTH * NR_COMMIT_PORTS + 40;
  localparam cause_t IRQ = cause_t'(1) << (XLEN - 1);

  typedef logic [NR_COMMIT_PORTS-1:0] port_vec_t;

  logic                         clk = 1'b0;
  logic                         rst_n;
  port_vec_t                    commit_ack;
  vaddr_t [NR_COMMIT_PORTS-1:0] commit_pc;
  insn_t  [NR_COMMIT_PORTS-1:0] commit_insn;
  port_vec_t                    commit_ex_valid;
  cause_t [NR_COMMIT_PORTS-1:0] commit_cause;
  priv_lvl_t                    priv_lvl;
  logic                         debug_mode;
  port_vec_t                    trace_valid;
  port_vec_t                    trace_exception;
  port_vec_t                    trace_interrupt;
  vaddr_t [NR_COMMIT_PORTS-1:0] trace_iaddr;
  insn_t  [NR_COMMIT_PORTS-1:0] trace_insn;
  cause_t [NR_COMMIT_PORTS-1:0] trace_cause;
  mode_t                        trace_mode;
  cycle_t                       trace_cycle;
  logic                         pc_valid;
  vaddr_t                       pc;
  port_vec_t                    pc_drop;

  // stimulus table with the expected trace bits and mode per row
  port_vec_t                    t_ack [N_ROWS];
  port_vec_t                    t_ex [N_ROWS];
  vaddr_t [NR_COMMIT_PORTS-1:0] t_pc [N_ROWS];
  insn_t  [NR_COMMIT_PORTS-1:0] t_insn [N_ROWS];
  cause_t [NR_COMMIT_PORTS-1:0] t_cause [N_ROWS];
  priv_lvl_t                    t_priv [N_ROWS];
  logic                         t_dbg [N_ROWS];
  port_vec_t                    t_exp_valid [N_ROWS];
  port_vec_t                    t_exp_exc [N_ROWS];
  port_vec_t                    t_exp_irq [N_ROWS];
  mode_t                        t_exp_mode [N_ROWS];

  // model queues and round-robin pointer
  vaddr_t model_q [NR_COMMIT_PORTS][$];
  int     model_ptr = 0;
  int     pend_idx = 0;
  logic   pend_valid = 1'b0;

  int     seed = 6;
  int     n_built = 0;
  int     cycle_cnt = 0;
  int     checks = 0;
  int     errors = 0;
  int     test_checks = 0;
  int     test_errors = 0;
  int     dropped = 0;
  string  cur_test;

  commit_tracer dut0 (
    .clk_i (clk), .rst_ni (rst_n),
    .commit_ack_i (commit_ack), .commit_pc_i (commit_pc), .commit_insn_i (commit_insn),
    .commit_ex_valid_i (commit_ex_valid), .commit_cause_i (commit_cause),
    .priv_lvl_i (priv_lvl), .debug_mode_i (debug_mode),
    .trace_valid_o (trace_valid), .trace_exception_o (trace_exception),
    .trace_interrupt_o (trace_interrupt), .trace_iaddr_o (trace_iaddr),
    .trace_insn_o (trace_insn), .trace_cause_o (trace_cause), .trace_mode_o (trace_mode),
    .trace_cycle_o (trace_cycle), .pc_valid_o (pc_valid), .pc_o (pc), .pc_drop_o (pc_drop)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the PC stream never drained", cycle_cnt);
      $display("sim failed");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // trace rules
  // ----------------------------------------------------------------------
  function automatic port_vec_t retire_of(port_vec_t ack, port_vec_t ex);
    return ack & ~ex;
  endfunction

  function automatic port_vec_t trap_of(port_vec_t ack, port_vec_t ex, cause_t c0, cause_t c1,
                                        logic irq);
    port_vec_t t;
    t[0] = ack[0] && ex[0] && (c0[XLEN-1] == irq);
    t[1] = ack[1] && ex[1] && (c1[XLEN-1] == irq);
    return t;
  endfunction

  function automatic mode_t mode_of(priv_lvl_t priv, logic dbg);
    if (dbg) begin
      return MODE_D;
    end
    case (priv)
      PRIV_LVL_U: return MODE_U;
      PRIV_LVL_S: return MODE_S;
      default:    return MODE_M;
    endcase
  endfunction

  task automatic add_row(input port_vec_t ack, input port_vec_t ex, input cause_t c0,
                         input cause_t c1, input priv_lvl_t priv, input logic dbg,
                         input port_vec_t ev, input port_vec_t ee, input port_vec_t ei,
                         input mode_t em);
    int r;
    r = n_built;
    t_ack[r] = ack;
    t_ex[r] = ex;
    t_cause[r] = {c1, c0};
    t_priv[r] = priv;
    t_dbg[r] = dbg;
    t_exp_valid[r] = ev;
    t_exp_exc[r] = ee;
    t_exp_irq[r] = ei;
    t_exp_mode[r] = em;
    // unique PC per row and port
    for (int p = 0; p < NR_COMMIT_PORTS; p++) begin
      t_pc[r][p] = vaddr_t'(64'h8000_0000 + 64'(r * 8 + p * 4));
      t_insn[r][p] = insn_t'($random(seed));
    end
    n_built = n_built + 1;
  endtask

  task automatic build_table();
    int        rnd;
    port_vec_t ack;
    port_vec_t ex;
    cause_t    c0;
    cause_t    c1;
    priv_lvl_t priv;
    logic      dbg;
    // retirement, classification and mode
    add_row(2'b11, 2'b00, '0, '0, PRIV_LVL_M, 1'b0, 2'b11, 2'b00, 2'b00, MODE_M);
    add_row(2'b01, 2'b00, '0, '0, PRIV_LVL_U, 1'b0, 2'b01, 2'b00, 2'b00, MODE_U);
    add_row(2'b10, 2'b00, '0, '0, PRIV_LVL_S, 1'b0, 2'b10, 2'b00, 2'b00, MODE_S);
    add_row(2'b11, 2'b11, 64'd2, IRQ | 64'd7, PRIV_LVL_M, 1'b0, 2'b00, 2'b01, 2'b10, MODE_M);
    add_row(2'b11, 2'b00, '0, '0, PRIV_LVL_U, 1'b1, 2'b11, 2'b00, 2'b00, MODE_D);
    add_row(2'b11, 2'b11, IRQ | 64'd3, 64'd5, PRIV_LVL_M, 1'b1, 2'b00, 2'b10, 2'b01, MODE_D);
    add_row(2'b00, 2'b11, 64'd2, IRQ, PRIV_LVL_S, 1'b0, 2'b00, 2'b00, 2'b00, MODE_S);
    add_row(2'b01, 2'b10, '0, 64'd4, PRIV_LVL_M, 1'b0, 2'b01, 2'b00, 2'b00, MODE_M);
    add_row(2'b10, 2'b01, IRQ, '0, PRIV_LVL_U, 1'b0, 2'b10, 2'b00, 2'b00, MODE_U);
    for (int i = 0; i < N_RANDOM; i++) begin
      rnd  = $random(seed);
      ack  = rnd[1:0];
      ex   = rnd[3:2] & rnd[5:4];
      dbg  = (rnd[8:6] == 3'b000);
      priv = (rnd[10:9] == 2'd2) ? PRIV_LVL_M : rnd[10:9];
      c0   = {$random(seed), $random(seed)};
      c1   = {$random(seed), $random(seed)};
      add_row(ack, ex, c0, c1, priv, dbg, retire_of(ack, ex), trap_of(ack, ex, c0, c1, 1'b0),
              trap_of(ack, ex, c0, c1, 1'b1), mode_of(priv, dbg));
    end
    // dual-port burst that outruns the arbiter
    for (int i = 0; i < N_BURST; i++) begin
      add_row(2'b11, 2'b00, '0, '0, PRIV_LVL_U, 1'b0, 2'b11, 2'b00, 2'b00, MODE_U);
    end
  endtask

  task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
    checks = checks + 1;
    test_checks = test_checks + 1;
    assert (act === exp) else begin
      $display("MISMATCH %s %s expected %h actual %h", cur_test, what, exp, act);
      errors = errors + 1;
      test_errors = test_errors + 1;
    end
  endtask

  task automatic end_test();
    $display("test %s finished: %0d checks, %0d errors", cur_test, test_checks, test_errors);
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic drive_row(input int k);
    commit_ack      <= t_ack[k];
    commit_ex_valid <= t_ex[k];
    commit_pc       <= t_pc[k];
    commit_insn     <= t_insn[k];
    commit_cause    <= t_cause[k];
    priv_lvl        <= t_priv[k];
    debug_mode      <= t_dbg[k];
  endtask

  task automatic check_trace(input int j);
    check_val("trace_valid", 64'(t_exp_valid[j]), 64'(trace_valid));
    check_val("trace_exception", 64'(t_exp_exc[j]), 64'(trace_exception));
    check_val("trace_interrupt", 64'(t_exp_irq[j]), 64'(trace_interrupt));
    check_val("trace_mode", 64'(t_exp_mode[j]), 64'(trace_mode));
    check_val("trace_cycle", 64'(j), trace_cycle);
    for (int p = 0; p < NR_COMMIT_PORTS; p++) begin
      if (t_exp_valid[j][p] || t_exp_exc[j][p] || t_exp_irq[j][p]) begin
        check_val("trace_iaddr", t_pc[j][p], trace_iaddr[p]);
        check_val("trace_insn", 64'(t_insn[j][p]), 64'(trace_insn[p]));
        check_val("trace_cause", t_cause[j][p], trace_cause[p]);
      end
    end
  endtask

  // one edge of the queues and the arbiter
  task automatic model_step(input port_vec_t retire, input vaddr_t [NR_COMMIT_PORTS-1:0] pcs);
    port_vec_t drop;
    logic      full;
    int        g;
    int        idx;
    drop = '0;
    for (int p = 0; p < NR_COMMIT_PORTS; p++) begin
      // full counts the entry granted in the previous cycle
      full = (model_q[p].size() >= int'(PC_QUEUE_DEPTH));
      if (pend_valid && pend_idx == p) begin
        void'(model_q[p].pop_front());
      end
      if (retire[p] && full) begin
        drop[p] = 1'b1;
      end else if (retire[p]) begin
        model_q[p].push_back(pcs[p]);
      end
    end
    check_val("pc_drop", 64'(drop), 64'(pc_drop));
    // drops the DUT actually signalled
    dropped = dropped + $countones(pc_drop);
    g = -1;
    for (int off = 0; off < NR_COMMIT_PORTS; off++) begin
      idx = (model_ptr + off) % NR_COMMIT_PORTS;
      if (g < 0 && model_q[idx].size() > 0) begin
        g = idx;
      end
    end
    check_val("pc_valid", 64'(g >= 0), 64'(pc_valid));
    pend_valid = (g >= 0);
    if (g >= 0) begin
      check_val("pc", model_q[g][0], pc);
      pend_idx = g;
      model_ptr = (g + 1) % NR_COMMIT_PORTS;
    end
  endtask

  initial begin
    rst_n = 1'b0;
    commit_ack = '0;
    commit_pc = '0;
    commit_insn = '0;
    commit_ex_valid = '0;
    commit_cause = '0;
    priv_lvl = PRIV_LVL_M;
    debug_mode = 1'b0;
    build_table();

    cur_test = "reset";
    repeat (8) begin
      @(posedge clk);
      @(negedge clk);
      check_val("trace_valid", '0, 64'(trace_valid));
      check_val("trace_exception", '0, 64'(trace_exception));
      check_val("trace_interrupt", '0, 64'(trace_interrupt));
      check_val("pc_valid", '0, 64'(pc_valid));
      check_val("pc_drop", '0, 64'(pc_drop));
    end
    end_test();

    // row k goes in at edge k and is checked after edge k+1
    cur_test = "directed";
    for (int k = 0; k <= N_ROWS; k++) begin
      @(posedge clk);
      if (k == 0) begin
        rst_n <= 1'b1;
      end
      if (k < N_ROWS) begin
        drive_row(k);
      end else begin
        commit_ack <= '0;
        commit_ex_valid <= '0;
      end
      @(negedge clk);
      if (k == N_DIRECTED + 1) begin
        end_test();
        cur_test = "random_stream";
      end else if (k == N_DIRECTED + N_RANDOM + 1) begin
        end_test();
        cur_test = "overflow";
      end
      if (k > 0) begin
        check_trace(k - 1);
        model_step(t_exp_valid[k-1], t_pc[k-1]);
      end else begin
        model_step('0, '0);
      end
    end

    // drain whatever the queues still hold
    while (model_q[0].size() + model_q[1].size() > 0) begin
      @(posedge clk);
      @(negedge clk);
      model_step('0, '0);
    end
    assert (dropped > 0) else begin
      $display("overflow burst never filled a queue, no PC was dropped");
      errors = errors + 1;
    end
    end_test();

    $display("total: %0d checks, %0d errors, %0d PCs dropped", checks, errors, dropped);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* commit_tracer_chk.sv */
`timescale 1ns/1ps

module commit_tracer_chk (
  input logic                                  clk_i,
  input logic                                  rst_ni,
  input logic [trace_pkg::NR_COMMIT_PORTS-1:0] trace_valid_i,
  input logic [trace_pkg::NR_COMMIT_PORTS-1:0] trace_exception_i,
  input logic [trace_pkg::NR_COMMIT_PORTS-1:0] trace_interrupt_i,
  input logic                                  pc_valid_i
);

  // ----------------------------------------------------------------------
  // trace record consistency
  // ----------------------------------------------------------------------

  // a trap is either an exception or an interrupt
  exc_irq_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (trace_exception_i & trace_interrupt_i) == '0)
    else $error("exception and interrupt both set on one port");

  // retirement and trap never share a port
  valid_no_trap: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (trace_valid_i & (trace_exception_i | trace_interrupt_i)) == '0)
    else $error("trace valid set together with a trap bit");

  // stream stays quiet in reset
  pc_quiet_in_reset: assert property (@(negedge clk_i) !rst_ni |-> !pc_valid_i)
    else $error("pc_valid_o high while in reset");

endmodule

bind commit_tracer commit_tracer_chk chk0 (
  .clk_i             ( clk_i             ),
  .rst_ni            ( rst_ni            ),
  .trace_valid_i     ( trace_valid_o     ),
  .trace_exception_i ( trace_exception_o ),
  .trace_interrupt_i ( trace_interrupt_o ),
  .pc_valid_i        ( pc_valid_o        )
);

/* commit_tracer.sv */
`timescale 1ns/1ps

module commit_tracer (
  input  logic                                               clk_i,
  input  logic                                               rst_ni,
  input  logic              [trace_pkg::NR_COMMIT_PORTS-1:0] commit_ack_i,
  input  riscv_pkg::vaddr_t [trace_pkg::NR_COMMIT_PORTS-1:0] commit_pc_i,
  input  riscv_pkg::insn_t  [trace_pkg::NR_COMMIT_PORTS-1:0] commit_insn_i,
  input  logic              [trace_pkg::NR_COMMIT_PORTS-1:0] commit_ex_valid_i,
  input  riscv_pkg::cause_t [trace_pkg::NR_COMMIT_PORTS-1:0] commit_cause_i,
  input  riscv_pkg::priv_lvl_t                               priv_lvl_i,
  input  logic                                               debug_mode_i,
  output logic              [trace_pkg::NR_COMMIT_PORTS-1:0] trace_valid_o,
  output logic              [trace_pkg::NR_COMMIT_PORTS-1:0] trace_exception_o,
  output logic              [trace_pkg::NR_COMMIT_PORTS-1:0] trace_interrupt_o,
  output riscv_pkg::vaddr_t [trace_pkg::NR_COMMIT_PORTS-1:0] trace_iaddr_o,
  output riscv_pkg::insn_t  [trace_pkg::NR_COMMIT_PORTS-1:0] trace_insn_o,
  output riscv_pkg::cause_t [trace_pkg::NR_COMMIT_PORTS-1:0] trace_cause_o,
  output trace_pkg::mode_t                                   trace_mode_o,
  output trace_pkg::cycle_t                                  trace_cycle_o,
  output logic                                               pc_valid_o,
  output riscv_pkg::vaddr_t                                  pc_o,
  output logic              [trace_pkg::NR_COMMIT_PORTS-1:0] pc_drop_o
);

  import riscv_pkg::*;
  import trace_pkg::*;

  // queue <-> arbiter
  logic   [NR_COMMIT_PORTS-1:0] q_empty;
  logic   [NR_COMMIT_PORTS-1:0] q_pop;
  vaddr_t [NR_COMMIT_PORTS-1:0] q_head_pc;

  commit_classifier i_classifier (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .commit_ack_i      ( commit_ack_i      ),
    .commit_pc_i       ( commit_pc_i       ),
    .commit_insn_i     ( commit_insn_i     ),
    .commit_ex_valid_i ( commit_ex_valid_i ),
    .commit_cause_i    ( commit_cause_i    ),
    .priv_lvl_i        ( priv_lvl_i        ),
    .debug_mode_i      ( debug_mode_i      ),
    .trace_valid_o     ( trace_valid_o     ),
    .trace_exception_o ( trace_exception_o ),
    .trace_interrupt_o ( trace_interrupt_o ),
    .trace_iaddr_o     ( trace_iaddr_o     ),
    .trace_insn_o      ( trace_insn_o      ),
    .trace_cause_o     ( trace_cause_o     ),
    .trace_mode_o      ( trace_mode_o      ),
    .trace_cycle_o     ( trace_cycle_o     )
  );

  // ----------------------------------------------------------------------
  // retired PC queues, one per commit port
  // ----------------------------------------------------------------------
  for (genvar i = 0; i < NR_COMMIT_PORTS; i++) begin : gen_pc_queue
    pc_queue #(
      .DEPTH ( PC_QUEUE_DEPTH )
    ) i_pc_queue (
      .clk_i             ( clk_i                ),
      .rst_ni            ( rst_ni               ),
      .commit_ack_i      ( commit_ack_i[i]      ),
      .commit_ex_valid_i ( commit_ex_valid_i[i] ),
      .commit_pc_i       ( commit_pc_i[i]       ),
      .pop_i             ( q_pop[i]             ),
      .empty_o           ( q_empty[i]           ),
      .head_pc_o         ( q_head_pc[i]         ),
      .drop_o            ( pc_drop_o[i]         )
    );
  end

  pc_rr_arbiter i_arbiter (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .empty_i    ( q_empty    ),
    .head_pc_i  ( q_head_pc  ),
    .pop_o      ( q_pop      ),
    .pc_valid_o ( pc_valid_o ),
    .pc_o       ( pc_o       )
  );

endmodule

/* pc_rr_arbiter.sv */
`timescale 1ns/1ps

module pc_rr_arbiter (
  input  logic                                               clk_i,
  input  logic                                               rst_ni,
  input  logic              [trace_pkg::NR_COMMIT_PORTS-1:0] empty_i,
  input  riscv_pkg::vaddr_t [trace_pkg::NR_COMMIT_PORTS-1:0] head_pc_i,
  output logic              [trace_pkg::NR_COMMIT_PORTS-1:0] pop_o,
  output logic                                               pc_valid_o,
  output riscv_pkg::vaddr_t                                  pc_o
);

  import trace_pkg::*;

  port_idx_t ptr_q;
  port_idx_t gnt_idx;
  logic      gnt_found;

  // ----------------------------------------------------------------------
  // first non-empty queue from the pointer onward
  // ----------------------------------------------------------------------
  always_comb begin
    int idx;
    gnt_found = 1'b0;
    gnt_idx   = ptr_q;
    pop_o     = '0;
    for (int off = 0; off < NR_COMMIT_PORTS; off++) begin
      idx = (int'(ptr_q) + off) % NR_COMMIT_PORTS;
      if (!gnt_found && !empty_i[idx]) begin
        gnt_found = 1'b1;
        gnt_idx   = port_idx_t'(idx);
      end
    end
    // granted head leaves its queue in the same cycle
    if (gnt_found) begin
      pop_o[gnt_idx] = 1'b1;
    end
  end

  assign pc_valid_o = gnt_found;
  assign pc_o       = head_pc_i[gnt_idx];

  // port after the granted one goes first next time
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q <= '0;
    end else if (gnt_found) begin
      ptr_q <= port_idx_t'((int'(gnt_idx) + 1) % NR_COMMIT_PORTS);
    end
  end

endmodule

/* pc_queue.sv */
`timescale 1ns/1ps

module pc_queue #(
  parameter int unsigned DEPTH = trace_pkg::PC_QUEUE_DEPTH
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              commit_ack_i,
  input  logic              commit_ex_valid_i,
  input  riscv_pkg::vaddr_t commit_pc_i,
  input  logic              pop_i,
  output logic              empty_o,
  output riscv_pkg::vaddr_t head_pc_o,
  output logic              drop_o
);

  import riscv_pkg::*;

  // DEPTH is a power of two, pointers carry one wrap bit
  localparam int unsigned AW = $clog2(DEPTH);

  vaddr_t      mem_q [DEPTH];
  logic [AW:0] wr_ptr_q;
  logic [AW:0] rd_ptr_q;
  logic        retire;
  logic        full;
  logic        empty;
  logic        push;
  logic        pop;
  logic        drop_q;

  assign empty = (wr_ptr_q == rd_ptr_q);
  assign full  = (wr_ptr_q[AW] != rd_ptr_q[AW]) &&
                 (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);

  // only plain retirements enter the queue
  assign retire = commit_ack_i & ~commit_ex_valid_i;

  // full is judged before this cycle's pop
  assign push = retire & ~full;
  assign pop  = pop_i & ~empty;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      drop_q   <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // one-cycle pulse for a lost PC
      drop_q <= retire & full;
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q[AW-1:0]] <= commit_pc_i;
    end
  end

  assign empty_o   = empty;
  assign head_pc_o = mem_q[rd_ptr_q[AW-1:0]];
  assign drop_o    = drop_q;

endmodule

/* commit_classifier.sv */
`timescale 1ns/1ps

module commit_classifier (
  input  logic                                               clk_i,
  input  logic                                               rst_ni,
  input  logic              [trace_pkg::NR_COMMIT_PORTS-1:0] commit_ack_i,
  input  riscv_pkg::vaddr_t [trace_pkg::NR_COMMIT_PORTS-1:0] commit_pc_i,
  input  riscv_pkg::insn_t  [trace_pkg::NR_COMMIT_PORTS-1:0] commit_insn_i,
  input  logic              [trace_pkg::NR_COMMIT_PORTS-1:0] commit_ex_valid_i,
  input  riscv_pkg::cause_t [trace_pkg::NR_COMMIT_PORTS-1:0] commit_cause_i,
  input  riscv_pkg::priv_lvl_t                               priv_lvl_i,
  input  logic                                               debug_mode_i,
  output logic              [trace_pkg::NR_COMMIT_PORTS-1:0] trace_valid_o,
  output logic              [trace_pkg::NR_COMMIT_PORTS-1:0] trace_exception_o,
  output logic              [trace_pkg::NR_COMMIT_PORTS-1:0] trace_interrupt_o,
  output riscv_pkg::vaddr_t [trace_pkg::NR_COMMIT_PORTS-1:0] trace_iaddr_o,
  output riscv_pkg::insn_t  [trace_pkg::NR_COMMIT_PORTS-1:0] trace_insn_o,
  output riscv_pkg::cause_t [trace_pkg::NR_COMMIT_PORTS-1:0] trace_cause_o,
  output trace_pkg::mode_t                                   trace_mode_o,
  output trace_pkg::cycle_t                                  trace_cycle_o
);

  import riscv_pkg::*;
  import trace_pkg::*;

  cycle_t                     cycle_q;
  mode_t                      mode_d;
  logic [NR_COMMIT_PORTS-1:0] valid_d;
  logic [NR_COMMIT_PORTS-1:0] exception_d;
  logic [NR_COMMIT_PORTS-1:0] interrupt_d;

  // counts edges since reset release, 0 in the first cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cycle_q <= '0;
    end else begin
      cycle_q <= cycle_q + cycle_t'(1);
    end
  end

  assign mode_d = debug_mode_i ? MODE_D : mode_t'({1'b0, priv_lvl_i});

  // ----------------------------------------------------------------------
  // classification per port
  // ----------------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < NR_COMMIT_PORTS; i++) begin
      valid_d[i]     = commit_ack_i[i] & ~commit_ex_valid_i[i];
      // top bit of the cause splits traps into exceptions and interrupts
      exception_d[i] = commit_ack_i[i] & commit_ex_valid_i[i] & ~commit_cause_i[i][XLEN-1];
      interrupt_d[i] = commit_ack_i[i] & commit_ex_valid_i[i] & commit_cause_i[i][XLEN-1];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      trace_valid_o     <= '0;
      trace_exception_o <= '0;
      trace_interrupt_o <= '0;
    end else begin
      trace_valid_o     <= valid_d;
      trace_exception_o <= exception_d;
      trace_interrupt_o <= interrupt_d;
    end
  end

  // record payload, qualified by the bits above
  always_ff @(posedge clk_i) begin
    trace_iaddr_o <= commit_pc_i;
    trace_insn_o  <= commit_insn_i;
    trace_cause_o <= commit_cause_i;
    trace_mode_o  <= mode_d;
    trace_cycle_o <= cycle_q;
  end

endmodule

/* trace_pkg.sv */
package trace_pkg;

  // ----------------------------------------------------------------------
  // tracer configuration
  // ----------------------------------------------------------------------

  // instructions retired per cycle at most
  localparam int unsigned NR_COMMIT_PORTS = 2;

  // retired PCs buffered per port
  localparam int unsigned PC_QUEUE_DEPTH = 16;

  // ----------------------------------------------------------------------
  // trace-side types
  // ----------------------------------------------------------------------

  typedef logic [0:0]  port_idx_t;
  typedef logic [63:0] cycle_t;

  // trace mode, privilege value or debug
  typedef logic [2:0] mode_t;

  localparam mode_t MODE_U = 3'd0;
  localparam mode_t MODE_S = 3'd1;
  localparam mode_t MODE_M = 3'd3;
  // debug mode wins over any privilege level
  localparam mode_t MODE_D = 3'd4;

endpackage

/* riscv_pkg.sv */
package riscv_pkg;

  // ----------------------------------------------------------------------
  // architectural widths
  // ----------------------------------------------------------------------

  // data and cause width
  localparam int unsigned XLEN = 64;

  // virtual address of a committed instruction
  typedef logic [63:0] vaddr_t;

  // raw instruction word, compressed ones zero extended
  typedef logic [31:0] insn_t;

  // exception cause, top bit set for interrupts
  typedef logic [XLEN-1:0] cause_t;

  // ----------------------------------------------------------------------
  // privilege levels
  // ----------------------------------------------------------------------

  typedef logic [1:0] priv_lvl_t;

  localparam priv_lvl_t PRIV_LVL_U = 2'd0;
  localparam priv_lvl_t PRIV_LVL_S = 2'd1;
  // level 2 is reserved
  localparam priv_lvl_t PRIV_LVL_M = 2'd3;

endpackage
